//--- common/rx_sync_fifo_pkg.sv
// fifo status layout and width helpers; depth fields assume DEPTH between 2 and 255
package rx_sync_fifo_pkg;

    // ------------------------------------------------------------
    // width limits
    // ------------------------------------------------------------

    localparam int unsigned FIFO_MAX_DEPTH_W = 8;   // depth field width, so at most 255 words

    // ------------------------------------------------------------
    // status word reported by the fifo controller
    // ------------------------------------------------------------

    typedef struct packed {
        logic [FIFO_MAX_DEPTH_W-1:0] depth;     // stored words, the output register included
        logic                        full;      // every slot is taken
        logic                        afull;     // depth has reached the programmed high watermark
        logic                        empty;     // nothing stored and nothing waiting at the output
        logic                        overflow;  // sticky, set by a push while full
        logic                        underflow; // sticky, set by a pop with no word ready
    } fifo_status_t;

    // ceiling of log2, used to size address and watermark fields
    // a value of 0 or 1 returns 0, so callers keep DEPTH at 2 or above
    function automatic int unsigned aw_logb2(input int unsigned value);
        int unsigned result;
        result = 0;
        for (int unsigned i = 0; i < 32; i++) begin
            if ((32'd1 << i) < value) begin
                result = i + 1;   // smallest power that still covers value
            end
        end
        return result;
    endfunction

endpackage

//--- common/rx_sync_clk_pkg.sv
// clock-control encodings; the idle-hold counter limits IDLE_HOLD to the range 1 to 15
package rx_sync_clk_pkg;

    // ------------------------------------------------------------
    // clock control state machine
    // ------------------------------------------------------------

    // the block starts asleep after reset and only the awake and draining states grant enable
    typedef enum logic [1:0] {
        CLK_ASLEEP   = 2'b00,   // enable withdrawn, waiting for activity
        CLK_AWAKE    = 2'b01,   // enable granted, port is busy
        CLK_DRAINING = 2'b10    // enable still granted, counting idle cycles
    } clk_ctl_state_t;

    // width of the counter that measures the run of idle cycles
    localparam int unsigned IDLE_HOLD_W = 4;

endpackage

//--- common/fifo_mem_if.sv
// memory port between the fifo controller and its storage; rdata is valid one cycle after re
`timescale 1ns/1ps

interface fifo_mem_if #(
    parameter int unsigned WIDTH   = 16,
    parameter int unsigned DEPTHB2 = 3
);

    logic               we;     // write strobe, takes effect at the clock edge
    logic [DEPTHB2-1:0] waddr;  // write address
    logic [WIDTH-1:0]   wdata;  // write data
    logic               re;     // read strobe
    logic [DEPTHB2-1:0] raddr;  // read address
    logic [WIDTH-1:0]   rdata;  // registered read data

    // the controller owns addresses and strobes
    modport ctrl (
        output we, waddr, wdata, re, raddr,
        input  rdata
    );

    // the storage side only returns read data
    modport mem (
        input  we, waddr, wdata, re, raddr,
        output rdata
    );

endinterface

//--- hw/rx_sync/rx_fifo_mem.sv
// register-file storage, one write and one registered read per cycle; contents are undefined after reset
`timescale 1ns/1ps

module rx_fifo_mem import rx_sync_fifo_pkg::*; #(
    parameter int unsigned DEPTH   = 8,
    parameter int unsigned WIDTH   = 16,
    parameter int unsigned DEPTHB2 = aw_logb2(DEPTH)
) (
    input  logic     hqm_inp_gated_clk,
    fifo_mem_if.mem  mem
);

    // ------------------------------------------------------------
    // storage array
    // ------------------------------------------------------------

    logic [WIDTH-1:0] mem_array [DEPTH];   // addresses stay below DEPTH
    logic [WIDTH-1:0] rdata_q;             // read register, only loaded on re

    // write lands at the edge where we is sampled high
    always_ff @(posedge hqm_inp_gated_clk) begin
        if (mem.we) begin
            mem_array[mem.waddr] <= mem.wdata;
        end
    end

    // read data shows one cycle after re and then holds until the next read
    always_ff @(posedge hqm_inp_gated_clk) begin
        if (mem.re) begin
            rdata_q <= mem_array[mem.raddr];
        end
    end

    assign mem.rdata = rdata_q;

endmodule

//--- hw/rx_sync/rx_fifo_control_wreg.sv
// fifo control with output register; cfg_high_wm must not exceed DEPTH or pushes can overflow
`timescale 1ns/1ps

module rx_fifo_control_wreg import rx_sync_fifo_pkg::*; #(
    parameter int unsigned DEPTH   = 8,
    parameter int unsigned WIDTH   = 16,
    parameter int unsigned DEPTHB2 = aw_logb2(DEPTH),       // memory address width
    parameter int unsigned WMWIDTH = aw_logb2(DEPTH + 1)    // holds 0 up to DEPTH
) (
    input  logic               hqm_inp_gated_clk,
    input  logic               hqm_inp_gated_rst_n,

    input  logic               push,
    input  logic [WIDTH-1:0]   push_data,
    input  logic               pop,
    output logic [WIDTH-1:0]   pop_data,
    output logic               pop_data_v,

    input  logic [WMWIDTH-1:0] cfg_high_wm,
    output fifo_status_t       status,
    output logic               afull,

    fifo_mem_if.ctrl           mem
);

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------

    logic [DEPTHB2-1:0] wptr_q;        // next slot to write
    logic [DEPTHB2-1:0] rptr_q;        // oldest word still in the memory
    logic [WMWIDTH-1:0] mem_cnt_q;     // words in the memory not yet read out
    logic               rdata_v_q;     // the memory read register holds an unread word
    logic               overflow_q;
    logic               underflow_q;

    logic [WMWIDTH-1:0] depth;         // total words, the output register included
    logic               full;
    logic               wr_en;
    logic               rd_en;
    logic               pop_ok;

    localparam logic [DEPTHB2-1:0] LAST_ADDR = DEPTHB2'(DEPTH - 1);

    assign depth  = mem_cnt_q + WMWIDTH'(rdata_v_q);
    assign full   = (depth >= WMWIDTH'(DEPTH));
    assign afull  = (depth >= cfg_high_wm);   // input stops once the watermark is met
    assign pop_ok = pop && rdata_v_q;          // a pop with nothing held is ignored

    // a push while full is dropped and only leaves its mark in overflow
    assign wr_en = push && !full;

    // refill the output register whenever it is empty or being emptied this cycle
    // the register only changes on a read, so it can never be loaded twice
    assign rd_en = (mem_cnt_q != '0) && (!rdata_v_q || pop_ok);

    // ------------------------------------------------------------
    // memory port
    // ------------------------------------------------------------

    // the read address never meets the write address in one cycle since a read
    // needs a word written on an earlier edge and a full memory takes no write
    assign mem.we    = wr_en;
    assign mem.waddr = wptr_q;
    assign mem.wdata = push_data;
    assign mem.re    = rd_en;
    assign mem.raddr = rptr_q;

    assign pop_data   = mem.rdata;   // the registered read side is the output register
    assign pop_data_v = rdata_v_q;

    always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
        if (!hqm_inp_gated_rst_n) begin
            wptr_q      <= '0;
            rptr_q      <= '0;
            mem_cnt_q   <= '0;
            rdata_v_q   <= 1'b0;
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else begin
            if (wr_en) begin
                wptr_q <= (wptr_q == LAST_ADDR) ? '0 : wptr_q + 1'b1;   // wraps for any DEPTH
            end
            if (rd_en) begin
                rptr_q <= (rptr_q == LAST_ADDR) ? '0 : rptr_q + 1'b1;
            end
            mem_cnt_q <= mem_cnt_q + WMWIDTH'(wr_en) - WMWIDTH'(rd_en);

            // a read lands in the register on the next edge, a pop alone clears it
            if (rd_en) begin
                rdata_v_q <= 1'b1;
            end else if (pop_ok) begin
                rdata_v_q <= 1'b0;
            end

            overflow_q  <= overflow_q || (push && full);          // held until reset
            underflow_q <= underflow_q || (pop && !rdata_v_q);
        end
    end

    // ------------------------------------------------------------
    // status word
    // ------------------------------------------------------------

    always_comb begin
        status.depth     = FIFO_MAX_DEPTH_W'(depth);
        status.full      = full;
        status.afull     = afull;
        status.empty     = (depth == '0);
        status.overflow  = overflow_q;
        status.underflow = underflow_q;
    end

endmodule

//--- hw/rx_sync/rx_sync_core.sv
// port glue around the fifo; with ENABLE_DROPREADY at 1 a sender waits until enable is granted
`timescale 1ns/1ps

module rx_sync_core #(
    parameter int unsigned WIDTH            = 16,
    parameter int unsigned ENABLE_DROPREADY = 1    // 1 drops in_ready while enable is low
) (
    input  logic             hqm_inp_gated_clk,
    input  logic             hqm_inp_gated_rst_n,

    input  logic             enable,      // grant from the clock control
    output logic             idle,        // report to the clock control
    input  logic             rst_prep,    // reset sequence is under way

    input  logic             in_valid,    // inbound parallel port
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,

    output logic             out_valid,   // internal side
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data,

    output logic             push,        // towards the fifo controller
    output logic [WIDTH-1:0] push_data,
    output logic             pop,
    input  logic [WIDTH-1:0] pop_data,
    input  logic             pop_data_v,
    input  logic             afull
);

    // ------------------------------------------------------------
    // sender presence
    // ------------------------------------------------------------

    // a word offered while enable is low is not pushed, so its valid is
    // remembered here to pull idle low and wake the clock control
    logic in_valid_q;

    // set when drop-ready is off and the port may accept without a grant
    localparam logic READY_WITHOUT_ENABLE = (ENABLE_DROPREADY == 0);

    always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
        if (!hqm_inp_gated_rst_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    // ------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------

    always_comb begin
        if (rst_prep) begin
            // the sender is drained, every offered word is taken and thrown away
            in_ready = 1'b1;
            push     = 1'b0;
            idle     = 1'b0;   // keep the clock running through the reset sequence
        end else begin
            in_ready = !afull && (enable || READY_WITHOUT_ENABLE);
            push     = in_valid && in_ready;
            idle     = !pop_data_v && !in_valid_q;   // nothing waiting and no sender knocking
        end
    end

    assign push_data = in_data;                 // stored as received
    assign out_valid = enable && pop_data_v;    // output register is only shown while enabled
    assign out_data  = pop_data;
    assign pop       = out_valid && out_ready;  // a transfer on the internal side empties the register

endmodule

//--- hw/module_clock_control.sv
// clock enable control; IDLE_HOLD must lie between 1 and 15, enable is a functional gate only
`timescale 1ns/1ps

module module_clock_control import rx_sync_clk_pkg::*; #(
    parameter int unsigned IDLE_HOLD = 4    // idle edges before enable is withdrawn
) (
    input  logic hqm_inp_gated_clk,
    input  logic hqm_inp_gated_rst_n,
    input  logic idle,      // port has nothing to do
    input  logic wake,      // external request to bring the port up
    output logic enable
);

    clk_ctl_state_t         state_q;
    clk_ctl_state_t         state_d;
    logic [IDLE_HOLD_W-1:0] hold_cnt_q;   // idle edges seen so far in the current run
    logic [IDLE_HOLD_W-1:0] hold_cnt_d;
    logic                   activity;

    localparam logic [IDLE_HOLD_W-1:0] HOLD_LAST = IDLE_HOLD_W'(IDLE_HOLD - 1);

    assign activity = !idle || wake;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------

    always_comb begin
        state_d    = state_q;
        hold_cnt_d = hold_cnt_q;
        case (state_q)
            CLK_ASLEEP: begin
                if (activity) begin
                    state_d    = CLK_AWAKE;   // grant on the next edge
                    hold_cnt_d = '0;
                end
            end
            CLK_AWAKE: begin
                if (!activity) begin
                    if (IDLE_HOLD <= 1) begin
                        state_d = CLK_ASLEEP;   // a single idle edge is enough
                    end else begin
                        state_d    = CLK_DRAINING;
                        hold_cnt_d = IDLE_HOLD_W'(1);   // this edge is the first of the run
                    end
                end
            end
            CLK_DRAINING: begin
                if (activity) begin
                    state_d    = CLK_AWAKE;   // the run is broken, start counting again later
                    hold_cnt_d = '0;
                end else if (hold_cnt_q == HOLD_LAST) begin
                    state_d    = CLK_ASLEEP;
                    hold_cnt_d = '0;
                end else begin
                    hold_cnt_d = hold_cnt_q + 1'b1;
                end
            end
            default: begin
                state_d    = CLK_ASLEEP;   // unused encoding falls back to the safe state
                hold_cnt_d = '0;
            end
        endcase
    end

    always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n) begin
        if (!hqm_inp_gated_rst_n) begin
            state_q    <= CLK_ASLEEP;
            hold_cnt_q <= '0;
        end else begin
            state_q    <= state_d;
            hold_cnt_q <= hold_cnt_d;
        end
    end

    assign enable = (state_q != CLK_ASLEEP);   // draining still holds the grant

endmodule

//--- hw/rx_sync_top.sv
// receive sync buffer top; DEPTH 2 to 255, cfg_high_wm at most DEPTH, IDLE_HOLD 1 to 15
`timescale 1ns/1ps

module rx_sync_top import rx_sync_fifo_pkg::*; #(
    parameter int unsigned DEPTH            = 8,
    parameter int unsigned WIDTH            = 16,
    parameter int unsigned ENABLE_DROPREADY = 1,
    parameter int unsigned IDLE_HOLD        = 4,
    parameter int unsigned DEPTHB2          = aw_logb2(DEPTH),
    parameter int unsigned WMWIDTH          = aw_logb2(DEPTH + 1)
) (
    input  logic               hqm_inp_gated_clk,
    input  logic               hqm_inp_gated_rst_n,
    input  logic [WMWIDTH-1:0] cfg_high_wm,   // most words the buffer will hold
    input  logic               rst_prep,
    input  logic               wake,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [WIDTH-1:0]   in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [WIDTH-1:0]   out_data,
    output fifo_status_t       status,
    output logic               idle,
    output logic               enable
);

    logic             push;
    logic [WIDTH-1:0] push_data;
    logic             pop;
    logic [WIDTH-1:0] pop_data;
    logic             pop_data_v;
    logic             afull;

    fifo_mem_if #(.WIDTH(WIDTH), .DEPTHB2(DEPTHB2)) i_fifo_mem_if ();

    rx_sync_core #(
        .WIDTH            (WIDTH),
        .ENABLE_DROPREADY (ENABLE_DROPREADY)
    ) i_rx_sync_core (
        .hqm_inp_gated_clk   (hqm_inp_gated_clk),
        .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
        .enable (enable), .idle (idle), .rst_prep (rst_prep),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .push (push), .push_data (push_data), .pop (pop),
        .pop_data (pop_data), .pop_data_v (pop_data_v), .afull (afull)
    );

    rx_fifo_control_wreg #(
        .DEPTH (DEPTH), .WIDTH (WIDTH), .DEPTHB2 (DEPTHB2), .WMWIDTH (WMWIDTH)
    ) i_rx_fifo_control_wreg (
        .hqm_inp_gated_clk   (hqm_inp_gated_clk),
        .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
        .push (push), .push_data (push_data), .pop (pop),
        .pop_data (pop_data), .pop_data_v (pop_data_v),
        .cfg_high_wm (cfg_high_wm), .status (status), .afull (afull),
        .mem (i_fifo_mem_if)
    );

    rx_fifo_mem #(
        .DEPTH (DEPTH), .WIDTH (WIDTH), .DEPTHB2 (DEPTHB2)
    ) i_rx_fifo_mem (
        .hqm_inp_gated_clk (hqm_inp_gated_clk),
        .mem               (i_fifo_mem_if)
    );

    module_clock_control #(.IDLE_HOLD (IDLE_HOLD)) i_module_clock_control (
        .hqm_inp_gated_clk   (hqm_inp_gated_clk),
        .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
        .idle (idle), .wake (wake), .enable (enable)
    );

endmodule

//--- verification/tb_rx_sync_top.sv
// built for DEPTH 8, WIDTH 16, IDLE_HOLD 4; inputs move 2 ns after the rising edge
`timescale 1ns/1ps

module tb_rx_sync_top import rx_sync_fifo_pkg::*; ();

    localparam int unsigned DEPTH     = 8;
    localparam int unsigned WIDTH     = 16;
    localparam int unsigned IDLE_HOLD = 4;
    localparam int unsigned WMWIDTH   = aw_logb2(DEPTH + 1);
    localparam int unsigned DRIVE_DLY = 2;      // ns after the rising edge
    localparam int unsigned NUM_WORDS = 300;

    // ------------------------------------------------------------
    // cycle budget with a quarter added on top of all phases
    // ------------------------------------------------------------
    localparam int unsigned RESET_CYC   = 10;
    localparam int unsigned PH1_CYC     = NUM_WORDS * 12;   // gaps plus back-pressure per word
    localparam int unsigned PH2_CYC     = 100;
    localparam int unsigned PH3_CYC     = 40;
    localparam int unsigned PH4_CYC     = 40;
    localparam int unsigned PH5_CYC     = 80;
    localparam int unsigned BUDGET_CYC  = RESET_CYC + PH1_CYC + PH2_CYC + PH3_CYC + PH4_CYC
                                          + PH5_CYC;
    localparam int unsigned CYCLE_LIMIT = BUDGET_CYC + BUDGET_CYC / 4;

    logic               hqm_inp_gated_clk;
    logic               hqm_inp_gated_rst_n;
    logic [WMWIDTH-1:0] cfg_high_wm;
    logic               rst_prep;
    logic               wake;
    logic               in_valid;
    logic               in_ready;
    logic [WIDTH-1:0]   in_data;
    logic               out_valid;
    logic               out_ready;
    logic [WIDTH-1:0]   out_data;
    fifo_status_t       status;
    logic               idle;
    logic               enable;

    logic [WIDTH-1:0]   model_q [$];      // every accepted word in arrival order
    int unsigned        error_cnt = 0;
    int unsigned        check_cnt = 0;
    int unsigned        cycle_cnt = 0;
    int unsigned        out_cnt   = 0;    // output transfers seen so far
    logic               sender_done;

    rx_sync_top #(
        .DEPTH (DEPTH), .WIDTH (WIDTH), .ENABLE_DROPREADY (1), .IDLE_HOLD (IDLE_HOLD)
    ) i_rx_sync_top (
        .hqm_inp_gated_clk   (hqm_inp_gated_clk),
        .hqm_inp_gated_rst_n (hqm_inp_gated_rst_n),
        .cfg_high_wm (cfg_high_wm), .rst_prep (rst_prep), .wake (wake),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .status (status), .idle (idle), .enable (enable)
    );

    initial begin
        hqm_inp_gated_clk = 1'b0;
        forever #10 hqm_inp_gated_clk = ~hqm_inp_gated_clk;   // 20 ns period
    end

    // expected next output word is the oldest one the model still holds
    function automatic logic [WIDTH-1:0] ref_pop();
        logic [WIDTH-1:0] word;
        word = model_q.pop_front();
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected,
                     $time);
            error_cnt++;
        end
    endtask

    task automatic next_drive();
        @(posedge hqm_inp_gated_clk);
        #DRIVE_DLY;   // inputs change well clear of the edge
    endtask

    // holds the word until in_ready is high and the transfer happens at the next edge
    task automatic send_word(input logic [WIDTH-1:0] data);
        in_valid = 1'b1;
        in_data  = data;
        do begin
            @(negedge hqm_inp_gated_clk);
        end while (!in_ready);
        next_drive();
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (model_q.size() != 0) begin
            next_drive();
        end
        repeat (2) next_drive();   // last word has left the output register
    endtask

    task automatic check_flags();
        check_value("status.overflow", status.overflow, 1'b0);
        check_value("status.underflow", status.underflow, 1'b0);
        check_value("status.empty", status.empty, model_q.size() == 0);
    endtask

    // ------------------------------------------------------------
    // monitor sampled mid-cycle where every handshake is settled
    // ------------------------------------------------------------
    always @(negedge hqm_inp_gated_clk) begin
        if (hqm_inp_gated_rst_n) begin
            // the model holds exactly the words the buffer should be storing now
            check_value("status.depth", status.depth, model_q.size());
            check_value("status.full", status.full, model_q.size() >= DEPTH);
            check_value("status.empty", status.empty, model_q.size() == 0);
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    $display("output sent word 0x%0h while no word was expected", out_data);
                    error_cnt++;
                end else begin
                    check_value("out_data", out_data, ref_pop());
                end
                out_cnt++;
            end
            if (in_valid && in_ready && !rst_prep) begin
                model_q.push_back(in_data);   // words offered during rst_prep are discarded
            end
        end
    end

    always @(posedge hqm_inp_gated_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("errors: %0d, checks: %0d", error_cnt + 1, check_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int unsigned      accepted;
        int unsigned      edges;
        int unsigned      out_before;
        int unsigned      gap;
        logic             took;
        void'($urandom(32'ha2f9));
        hqm_inp_gated_rst_n = 1'b0;
        cfg_high_wm = WMWIDTH'(8);
        rst_prep    = 1'b0;
        wake        = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        sender_done = 1'b0;
        repeat (RESET_CYC) @(posedge hqm_inp_gated_clk);
        #DRIVE_DLY;
        hqm_inp_gated_rst_n = 1'b1;
        check_value("enable", enable, 1'b0);   // quiet state straight out of reset
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_ready", in_ready, 1'b0);
        check_value("idle", idle, 1'b1);
        check_value("mem.we", i_rx_sync_top.i_fifo_mem_if.we, 1'b0);
        check_value("mem.re", i_rx_sync_top.i_fifo_mem_if.re, 1'b0);
        check_value("status.empty", status.empty, 1'b1);

        // ------------------------------------------------------------
        // ordering under random gaps and back-pressure
        // ------------------------------------------------------------
        fork
            begin
                for (int i = 0; i < NUM_WORDS; i++) begin
                    gap = $urandom % 4;
                    repeat (gap) next_drive();
                    send_word(WIDTH'($urandom));
                end
                sender_done = 1'b1;
            end
            begin
                while (!sender_done) begin
                    out_ready = ($urandom % 4) != 0;   // ready about three cycles in four
                    next_drive();
                end
            end
        join
        out_ready = 1'b1;
        wait_drain();
        check_value("words out", out_cnt, NUM_WORDS);
        check_flags();

        // watermark at 5 with the output stalled
        cfg_high_wm = WMWIDTH'(5);
        out_ready   = 1'b0;
        accepted    = 0;
        in_valid    = 1'b1;
        in_data     = WIDTH'($urandom);
        repeat (40) begin
            @(negedge hqm_inp_gated_clk);
            took = in_ready;   // valid is held, so ready here means a transfer
            if (took) accepted++;
            next_drive();
            if (took) in_data = WIDTH'($urandom);
        end
        check_value("accepted words", accepted, 5);
        check_value("in_ready", in_ready, 1'b0);
        check_value("status.depth", status.depth, 5);
        check_value("status.afull", status.afull, 1'b1);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        wait_drain();
        cfg_high_wm = WMWIDTH'(8);
        check_flags();

        // ------------------------------------------------------------
        // idle hold and wake
        // ------------------------------------------------------------
        while (enable) next_drive();
        check_value("idle", idle, 1'b1);
        wake = 1'b1;
        next_drive();
        check_value("enable after wake", enable, 1'b1);
        repeat (2) next_drive();
        wake  = 1'b0;
        edges = 0;
        do begin
            next_drive();
            edges++;
        end while (enable && edges < 20);
        check_value("idle edges to sleep", edges, IDLE_HOLD);

        // a sender knocking while asleep wakes the port
        check_value("in_ready asleep", in_ready, 1'b0);
        out_before = out_cnt;
        send_word(WIDTH'($urandom));
        check_value("enable after sender", enable, 1'b1);
        wait_drain();
        check_value("words out", out_cnt, out_before + 1);
        check_flags();

        // ------------------------------------------------------------
        // reset preparation with three words parked in the buffer
        // ------------------------------------------------------------
        out_ready   = 1'b0;
        out_before  = out_cnt;
        cfg_high_wm = WMWIDTH'(3);   // the parked words meet the watermark and drop in_ready
        repeat (3) send_word(WIDTH'($urandom));
        check_value("status.depth", status.depth, model_q.size());
        check_value("in_ready at watermark", in_ready, 1'b0);
        rst_prep = 1'b1;
        #1;
        check_value("in_ready in rst_prep", in_ready, 1'b1);
        for (int i = 0; i < 6; i++) begin
            in_valid = 1'b1;
            in_data  = WIDTH'($urandom);
            next_drive();
        end
        in_valid = 1'b0;
        check_value("status.depth in rst_prep", status.depth, 3);
        out_ready = 1'b1;
        wait_drain();
        // buffer empty and no sender, so only rst_prep keeps idle low
        check_value("idle in rst_prep", idle, 1'b0);
        rst_prep    = 1'b0;
        cfg_high_wm = WMWIDTH'(8);
        repeat (3) next_drive();   // any discarded word would show up by now
        check_value("out_valid", out_valid, 1'b0);
        check_value("words out", out_cnt, out_before + 3);
        check_flags();

        $display("errors: %0d, checks: %0d", error_cnt, check_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/rx_sync_fifo_pkg.sv
common/rx_sync_clk_pkg.sv
common/fifo_mem_if.sv
hw/rx_sync/rx_fifo_mem.sv
hw/rx_sync/rx_fifo_control_wreg.sv
hw/rx_sync/rx_sync_core.sv
hw/module_clock_control.sv
hw/rx_sync_top.sv
verification/tb_rx_sync_top.sv

//--- Bender.yml
package:
  name: rx_sync

sources:
  # packages and the interface come first
  - common/rx_sync_fifo_pkg.sv
  - common/rx_sync_clk_pkg.sv
  - common/fifo_mem_if.sv
  # design
  - hw/rx_sync/rx_fifo_mem.sv
  - hw/rx_sync/rx_fifo_control_wreg.sv
  - hw/rx_sync/rx_sync_core.sv
  - hw/module_clock_control.sv
  - hw/rx_sync_top.sv
  # testbench
  - target: test
    files:
      - verification/tb_rx_sync_top.sv
